/* Makefile */
# Verilator build and run for the interpolation front end testbench

TOP = sddac_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

/* sources.f */
+incdir+src
src/sddac_pkg.sv
src/dp_ram.sv
src/dsp_mac.sv
src/fir_interp_8x.sv
src/sddac_regs.sv
src/sddac_interp_top.sv
verification/tb_clock_gen.sv
verification/sddac_tb.sv

/* src/dp_ram.sv */
// Simple dual-port RAM
// One synchronous write port, one read port with registered output

`timescale 1ns/1ps

module dp_ram #(
    parameter int DATA_W = 36,
    parameter int DEPTH  = 7
) (
    input  logic                     clk,
    input  logic                     wr,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [DATA_W-1:0]        wr_data,
    input  logic                     rd,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [DATA_W-1:0]        rd_data
);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
        // Read data holds while rd is low
        if (rd) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* src/dsp_mac.sv */
// Multiply-accumulate slice shaped like a DSP block
// Stage 1 registers operands and opcode, stage 2 updates the accumulator

`timescale 1ns/1ps

module dsp_mac (
    input  logic               clk,
    input  logic               reset,
    input  sddac_pkg::dsp_op_e op,
    input  sddac_pkg::sample_t a,
    input  sddac_pkg::sample_t b,
    output sddac_pkg::acc_t    p
);

    sddac_pkg::dsp_op_e op_q;
    sddac_pkg::sample_t a_q;
    sddac_pkg::sample_t b_q;
    sddac_pkg::acc_t    prod;

    // Input registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_q <= sddac_pkg::NOP;
        end else begin
            op_q <= op;
        end
    end

    always_ff @(posedge clk) begin
        a_q <= a;
        b_q <= b;
    end

    // Sign extended to accumulator width
    assign prod = a_q * b_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p <= '0;
        end else begin
            case (op_q)
                sddac_pkg::MULT: p <= prod;
                sddac_pkg::MACC: p <= p + prod;
                default:         p <= p;
            endcase
        end
    end

endmodule

/* src/fir_interp_8x.sv */
// Polyphase 8x interpolating FIR, 8 phases of 7 taps, stereo
// Sequencer drives a shared delay line and two external MAC slices

`timescale 1ns/1ps

`include "sddac_cfg.svh"

module fir_interp_8x (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  logic               mute,
    input  logic [1:0]         gain_shift,
    input  logic               in_valid,
    input  sddac_pkg::sample_t in_l,
    input  sddac_pkg::sample_t in_r,
    output logic               out_valid,
    output sddac_pkg::sample_t out_l,
    output sddac_pkg::sample_t out_r,
    output logic               done,
    output logic               in_accept,
    output logic               overrun,
    output sddac_pkg::dsp_op_e dsp_op,
    output sddac_pkg::sample_t dsp_a,
    output sddac_pkg::sample_t dsp_b_l,
    output sddac_pkg::sample_t dsp_b_r,
    input  sddac_pkg::acc_t    dsp_p_l,
    input  sddac_pkg::acc_t    dsp_p_r
);

    localparam int TAPS   = `SDDAC_TAPS;
    localparam int PHASES = `SDDAC_PHASES;
    localparam int IDX_W  = $clog2(TAPS);
    localparam int PH_W   = $clog2(PHASES);
    localparam int NCOEF  = TAPS * PHASES;
    localparam int HALF   = NCOEF / 2;
    localparam int CIDX_W = $clog2(NCOEF);
    localparam int HIDX_W = $clog2(HALF);
    localparam int LINE_W = 2 * `SDDAC_SAMPLE_W;

    localparam sddac_pkg::acc_t SAT_MAX = sddac_pkg::acc_t'((1 << (`SDDAC_SAMPLE_W - 1)) - 1);
    localparam sddac_pkg::acc_t SAT_MIN = -SAT_MAX - 1;

    // First half of the symmetric prototype, c[k] == c[55-k]
    localparam sddac_pkg::sample_t COEF_HALF [HALF] = '{
        18'h3FFF4, 18'h3FFF0, 18'h3FFFE, 18'h00031,
        18'h00098, 18'h00138, 18'h00201, 18'h002C3,
        18'h0032F, 18'h002DC, 18'h0015F, 18'h3FE65,
        18'h3F9DC, 18'h3F417, 18'h3EDE7, 18'h3E89D,
        18'h3E5F2, 18'h3E7CE, 18'h3EFF9, 18'h3FFB9,
        18'h01781, 18'h036A8, 18'h05B56, 18'h082A2,
        18'h0A8DF, 18'h0CA17, 18'h0E2A1, 18'h0EFAA
    };

    sddac_pkg::fir_state_e state;
    sddac_pkg::fir_state_e state_nxt;

    logic [IDX_W-1:0]   rep_cnt;
    logic               rep_last;
    logic [IDX_W-1:0]   i_idx;
    logic [PH_W-1:0]    j_idx;
    logic               last_phase;
    logic [IDX_W-1:0]   ix;
    logic [IDX_W-1:0]   head;
    logic               take;
    sddac_pkg::sample_t in_l_q;
    sddac_pkg::sample_t in_r_q;

    logic               line_wr;
    logic [LINE_W-1:0]  line_wr_data;
    logic               line_rd;
    logic [LINE_W-1:0]  line_rd_data;

    logic [CIDX_W-1:0]  coef_idx;
    logic [CIDX_W-1:0]  coef_mirror;
    sddac_pkg::sample_t coef;

    // Arithmetic shift, then clamp to the sample range
    function automatic sddac_pkg::sample_t scale_out(input sddac_pkg::acc_t acc,
                                                     input logic [1:0] shift);
        sddac_pkg::acc_t shifted;
        shifted = acc >>> (`SDDAC_OUT_LSB - shift);
        if (shifted > SAT_MAX) begin
            return sddac_pkg::sample_t'(SAT_MAX);
        end else if (shifted < SAT_MIN) begin
            return sddac_pkg::sample_t'(SAT_MIN);
        end
        return sddac_pkg::sample_t'(shifted);
    endfunction

    // --------------------
    // Sequencer
    // --------------------
    assign take       = in_valid && enable && (state == sddac_pkg::WAIT_IN);
    assign rep_last   = (rep_cnt == IDX_W'(TAPS - 1));
    assign last_phase = (j_idx == PH_W'(PHASES - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            sddac_pkg::INIT:       if (rep_last) state_nxt = sddac_pkg::WAIT_IN;
            sddac_pkg::WAIT_IN:    if (take) state_nxt = sddac_pkg::LOAD;
            sddac_pkg::LOAD:       state_nxt = sddac_pkg::MAC;
            sddac_pkg::MAC:        if (rep_last) state_nxt = sddac_pkg::NEXT_PHASE;
            sddac_pkg::NEXT_PHASE: state_nxt = sddac_pkg::DRAIN;
            sddac_pkg::DRAIN:      state_nxt = sddac_pkg::RESULT;
            sddac_pkg::RESULT: begin
                state_nxt = last_phase ? sddac_pkg::WAIT_IN : sddac_pkg::MAC;
            end
            default:               state_nxt = sddac_pkg::INIT;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= sddac_pkg::INIT;
            rep_cnt <= '0;
            i_idx   <= '0;
            j_idx   <= '0;
            ix      <= '0;
            head    <= '0;
        end else begin
            state <= state_nxt;
            // Repeat counter only runs in the 7-cycle states
            if ((state == sddac_pkg::INIT || state == sddac_pkg::MAC) && !rep_last) begin
                rep_cnt <= rep_cnt + 1'b1;
            end else begin
                rep_cnt <= '0;
            end
            if (line_wr) begin
                head <= (head == '0) ? IDX_W'(TAPS - 1) : head - 1'b1;
            end
            case (state)
                sddac_pkg::LOAD: begin
                    i_idx <= '0;
                    j_idx <= '0;
                    ix    <= head;
                end
                sddac_pkg::MAC: begin
                    i_idx <= i_idx + 1'b1;
                    // 7 steps bring ix back to the head for the next phase
                    ix    <= (ix == IDX_W'(TAPS - 1)) ? '0 : ix + 1'b1;
                end
                sddac_pkg::NEXT_PHASE: i_idx <= '0;
                sddac_pkg::RESULT:     if (!last_phase) j_idx <= j_idx + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            in_l_q <= in_l;
            in_r_q <= in_r;
        end
    end

    // --------------------
    // Delay line
    // --------------------
    assign line_wr      = (state == sddac_pkg::INIT) || (state == sddac_pkg::LOAD);
    assign line_wr_data = (state == sddac_pkg::INIT) ? '0 : {in_l_q, in_r_q};
    assign line_rd      = (state == sddac_pkg::MAC);

    dp_ram #(
        .DATA_W (LINE_W),
        .DEPTH  (TAPS)
    ) delay_line (
        .clk     (clk),
        .wr      (line_wr),
        .wr_addr (head),
        .wr_data (line_wr_data),
        .rd      (line_rd),
        .rd_addr (ix),
        .rd_data (line_rd_data)
    );

    // --------------------
    // Coefficients and MAC drive
    // --------------------
    assign coef_idx    = CIDX_W'(j_idx) * CIDX_W'(TAPS) + CIDX_W'(i_idx);
    assign coef_mirror = CIDX_W'(NCOEF - 1) - coef_idx;
    assign coef        = (coef_idx < CIDX_W'(HALF)) ? COEF_HALF[coef_idx[HIDX_W-1:0]]
                                                    : COEF_HALF[coef_mirror[HIDX_W-1:0]];

    // Op and coefficient delayed one cycle to line up with the RAM read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dsp_op <= sddac_pkg::NOP;
        end else if (state == sddac_pkg::MAC) begin
            dsp_op <= (i_idx == '0) ? sddac_pkg::MULT : sddac_pkg::MACC;
        end else begin
            dsp_op <= sddac_pkg::NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (state == sddac_pkg::MAC) begin
            dsp_a <= coef;
        end
    end

    assign dsp_b_l = line_rd_data[LINE_W-1:`SDDAC_SAMPLE_W];
    assign dsp_b_r = line_rd_data[`SDDAC_SAMPLE_W-1:0];

    // --------------------
    // Outputs and status pulses
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            done      <= 1'b0;
            in_accept <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            out_valid <= (state == sddac_pkg::RESULT);
            done      <= (state == sddac_pkg::RESULT) && last_phase;
            in_accept <= take;
            overrun   <= in_valid && enable && (state != sddac_pkg::WAIT_IN);
        end
    end

    always_ff @(posedge clk) begin
        if (state == sddac_pkg::RESULT) begin
            out_l <= mute ? '0 : scale_out(dsp_p_l, gain_shift);
            out_r <= mute ? '0 : scale_out(dsp_p_r, gain_shift);
        end
    end

endmodule

/* src/sddac_cfg.svh */
// Configuration for the stereo interpolation DAC front end
// Widths, filter geometry and APB register map

`ifndef SDDAC_CFG_SVH
`define SDDAC_CFG_SVH

// Datapath widths
`define SDDAC_SAMPLE_W 18
`define SDDAC_ACC_W 48

// Polyphase geometry, 8 phases of 7 taps
`define SDDAC_TAPS 7
`define SDDAC_PHASES 8
`define SDDAC_OUT_LSB 16

// APB register map
`define SDDAC_APB_AW 4
`define SDDAC_REG_CTRL 4'h0
`define SDDAC_REG_STATUS 4'h4
`define SDDAC_REG_COUNT 4'h8

`endif

/* src/sddac_interp_top.sv */
// Interpolation front end of the stereo sigma-delta DAC
// APB registers, polyphase FIR and one MAC slice per channel

`timescale 1ns/1ps

`include "sddac_cfg.svh"

module sddac_interp_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`SDDAC_APB_AW-1:0] paddr,
    input  sddac_pkg::apb_data_t     pwdata,
    output sddac_pkg::apb_data_t     prdata,
    input  logic                     in_valid,
    input  sddac_pkg::sample_t       in_l,
    input  sddac_pkg::sample_t       in_r,
    output logic                     out_valid,
    output sddac_pkg::sample_t       out_l,
    output sddac_pkg::sample_t       out_r,
    output logic                     done
);

    logic               enable;
    logic               mute;
    logic [1:0]         gain_shift;
    logic               in_accept;
    logic               overrun;
    sddac_pkg::dsp_op_e dsp_op;
    sddac_pkg::sample_t dsp_a;
    sddac_pkg::sample_t dsp_b_l;
    sddac_pkg::sample_t dsp_b_r;
    sddac_pkg::acc_t    dsp_p_l;
    sddac_pkg::acc_t    dsp_p_r;

    sddac_regs sddac_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .enable     (enable),
        .mute       (mute),
        .gain_shift (gain_shift),
        .in_accept  (in_accept),
        .overrun    (overrun)
    );

    fir_interp_8x fir_interp_8x_inst (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .mute       (mute),
        .gain_shift (gain_shift),
        .in_valid   (in_valid),
        .in_l       (in_l),
        .in_r       (in_r),
        .out_valid  (out_valid),
        .out_l      (out_l),
        .out_r      (out_r),
        .done       (done),
        .in_accept  (in_accept),
        .overrun    (overrun),
        .dsp_op     (dsp_op),
        .dsp_a      (dsp_a),
        .dsp_b_l    (dsp_b_l),
        .dsp_b_r    (dsp_b_r),
        .dsp_p_l    (dsp_p_l),
        .dsp_p_r    (dsp_p_r)
    );

    // Both slices share opcode and coefficient
    dsp_mac mac_l (
        .clk   (clk),
        .reset (reset),
        .op    (dsp_op),
        .a     (dsp_a),
        .b     (dsp_b_l),
        .p     (dsp_p_l)
    );

    dsp_mac mac_r (
        .clk   (clk),
        .reset (reset),
        .op    (dsp_op),
        .a     (dsp_a),
        .b     (dsp_b_r),
        .p     (dsp_p_r)
    );

endmodule

/* src/sddac_pkg.sv */
// Shared types for the stereo interpolation DAC front end

`include "sddac_cfg.svh"

package sddac_pkg;

    // Audio sample or filter coefficient
    typedef logic signed [`SDDAC_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`SDDAC_ACC_W-1:0] acc_t;
    typedef logic [31:0] apb_data_t;

    typedef enum logic [1:0] {
        NOP,
        MULT,
        MACC
    } dsp_op_e;

    typedef enum logic [2:0] {
        INIT,
        WAIT_IN,
        LOAD,
        MAC,
        NEXT_PHASE,
        DRAIN,
        RESULT
    } fir_state_e;

endpackage

/* src/sddac_regs.sv */
// APB register block for the interpolator
// CTRL steers the filter, STATUS holds a sticky overrun flag,
// COUNT tallies accepted input samples

`timescale 1ns/1ps

`include "sddac_cfg.svh"

module sddac_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`SDDAC_APB_AW-1:0] paddr,
    input  sddac_pkg::apb_data_t     pwdata,
    output sddac_pkg::apb_data_t     prdata,
    output logic                     enable,
    output logic                     mute,
    output logic [1:0]               gain_shift,
    input  logic                     in_accept,
    input  logic                     overrun
);

    logic        wr_en;
    logic        ovr_flag;
    logic [15:0] sample_cnt;

    // Access phase write, no wait states
    assign wr_en = psel && penable && pwrite;

    // --------------------
    // CTRL
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable     <= 1'b0;
            mute       <= 1'b0;
            gain_shift <= 2'b00;
        end else if (wr_en && paddr == `SDDAC_REG_CTRL) begin
            enable     <= pwdata[0];
            mute       <= pwdata[1];
            gain_shift <= pwdata[3:2];
        end
    end

    // --------------------
    // STATUS and COUNT
    // --------------------
    // New overrun wins over a clear in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ovr_flag <= 1'b0;
        end else if (overrun) begin
            ovr_flag <= 1'b1;
        end else if (wr_en && paddr == `SDDAC_REG_STATUS && pwdata[0]) begin
            ovr_flag <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_cnt <= '0;
        end else if (in_accept) begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    // Read mux, unmapped reads return zero
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                `SDDAC_REG_CTRL:   prdata = {28'd0, gain_shift, mute, enable};
                `SDDAC_REG_STATUS: prdata = {31'd0, ovr_flag};
                `SDDAC_REG_COUNT:  prdata = {16'd0, sample_cnt};
                default:           prdata = '0;
            endcase
        end
    end

endmodule

/* verification/sddac_interp_trace.txt */
# Columns: command, then two values. W addr data, R addr expected (hex)
# S left right, E expected left right (signed decimal), X drops the next S
R 0 0
R 4 0
R 8 0
W 0 c
R 0 c
R c 0
W 0 1
E 24 24
E -1414 -1414
E 9266 9266
E -27984 -27984
E -122708 -122708
E -12034 -12034
E 6098 6098
E -1026 -1026
S -131072 -131072
E 32 32
E -1630 -1630
E 11974 11974
E -46764 -46764
E -116034 -116034
E 142 142
E 3144 3144
E -624 -624
S 0 0
E 4 4
E -1464 -1464
E 13340 13340
E -66884 -66884
E -103470 -103470
E 8206 8206
E 822 822
E -304 -304
S 0 0
E -98 -98
E -702 -702
E 12388 12388
E -86462 -86462
E -86462 -86462
E 12388 12388
E -702 -702
E -98 -98
S 0 0
E -304 -304
E 822 822
E 8206 8206
E -103470 -103470
E -66884 -66884
E 13340 13340
E -1464 -1464
E 4 4
S 0 0
E -624 -624
E 3144 3144
E 142 142
E -116034 -116034
E -46764 -46764
E 11974 11974
E -1630 -1630
E 32 32
S 0 0
E -1026 -1026
E 6098 6098
E -12034 -12034
E -122708 -122708
E -27984 -27984
E 9266 9266
E -1414 -1414
E 24 24
S 0 0
W 0 d
E 192 -96
E -11312 5656
E 74128 -37064
E -131072 111936
E -131072 131071
E -96272 48136
E 48784 -24392
E -8208 4104
S -131072 65536
W 0 1
E 20 -16
E -923 815
E 7341 -5987
E -32772 23382
E -54680 58017
E 6159 -71
E 95 -1572
E -111 312
S 65536 0
E -12 -8
E -649 1085
E 7353 -8987
E -43502 40438
E -45453 82412
E 8135 -1095
E -750 -1936
E 8 408
S 0 32768
W 0 3
E 0 0
E 0 0
E 0 0
E 0 0
E 0 0
E 0 0
E 0 0
E 0 0
S 1000 1000
X
S 7 7
R 4 1
W 4 1
R 4 0
W 0 0
S 5 5
R 8 b

/* verification/sddac_tb.sv */
// Trace-driven testbench for the interpolation front end
// APB access, sample driver, output monitor with value and timing checks

`timescale 1ns/1ps

`include "sddac_cfg.svh"

module sddac_tb;

    logic                     clk;
    logic                     reset;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`SDDAC_APB_AW-1:0] paddr;
    sddac_pkg::apb_data_t     pwdata;
    sddac_pkg::apb_data_t     prdata;
    logic                     in_valid;
    sddac_pkg::sample_t       in_l;
    sddac_pkg::sample_t       in_r;
    logic                     out_valid;
    sddac_pkg::sample_t       out_l;
    sddac_pkg::sample_t       out_r;
    logic                     done;

    sddac_pkg::sample_t exp_l_q[$];
    sddac_pkg::sample_t exp_r_q[$];
    int                 exp_line_q[$];
    string              trace_text[$];
    int                 trace_num[$];

    int value_errors = 0;
    int timing_errors = 0;
    int other_errors = 0;
    int cyc = 0;
    int accept_stamp = 0;
    int grp_idx = 0;
    int n_cmds = 0;
    bit loaded = 1'b0;

    tb_clock_gen clk_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    sddac_interp_top sddac_interp_top_inst (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .in_valid  (in_valid),
        .in_l      (in_l),
        .in_r      (in_r),
        .out_valid (out_valid),
        .out_l     (out_l),
        .out_r     (out_r),
        .done      (done)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_sample(input string name, input sddac_pkg::sample_t exp,
                                input sddac_pkg::sample_t act);
        if (exp !== act) begin
            value_errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input sddac_pkg::apb_data_t exp,
                             input sddac_pkg::apb_data_t act);
        if (exp !== act) begin
            value_errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // --------------------
    // Bus and sample drivers
    // --------------------
    task automatic apb_write(input logic [`SDDAC_APB_AW-1:0] addr,
                             input sddac_pkg::apb_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [`SDDAC_APB_AW-1:0] addr,
                            output sddac_pkg::apb_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        // Access phase ends at this edge
        @(posedge clk);
        data = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Stamp is the cycle count seen at the edge that samples in_valid
    task automatic send_sample(input int l, input int r, output int stamp);
        @(posedge clk);
        in_valid <= 1'b1;
        in_l     <= sddac_pkg::sample_t'(l);
        in_r     <= sddac_pkg::sample_t'(r);
        stamp = cyc + 1;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_done();
        @(posedge clk);
        while (!done) begin
            @(posedge clk);
        end
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(3, 0)) @(posedge clk);
    endtask

    // --------------------
    // Output monitor
    // --------------------
    always @(posedge clk) begin
        int line_no;
        if (!reset) begin
            if (out_valid) begin
                if (exp_l_q.size() == 0) begin
                    other_errors++;
                    $display("output %0d %0d appeared with nothing expected", out_l, out_r);
                end else begin
                    line_no = exp_line_q.pop_front();
                    check_sample($sformatf("trace line %0d left", line_no),
                                 exp_l_q.pop_front(), out_l);
                    check_sample($sformatf("trace line %0d right", line_no),
                                 exp_r_q.pop_front(), out_r);
                end
                if (cyc != accept_stamp + 12 + 10 * grp_idx) begin
                    timing_errors++;
                    $display("output %0d of a group came at cycle %0d instead of cycle %0d",
                             grp_idx, cyc, accept_stamp + 12 + 10 * grp_idx);
                end
                if (done !== (grp_idx == 7)) begin
                    timing_errors++;
                    $display("done was %b on output %0d of a group", done, grp_idx);
                end
                grp_idx = (grp_idx == 7) ? 0 : grp_idx + 1;
            end else if (done) begin
                timing_errors++;
                $display("done pulsed without out_valid at cycle %0d", cyc);
            end
        end
    end

    // --------------------
    // Trace loading and replay
    // --------------------
    task automatic load_trace(output bit ok);
        int    fd;
        int    num;
        string text;
        fd  = $fopen("verification/sddac_interp_trace.txt", "r");
        num = 0;
        ok  = (fd != 0);
        if (ok) begin
            while ($fgets(text, fd) != 0) begin
                num++;
                if (text.len() > 1 && text[0] != "#") begin
                    trace_text.push_back(text);
                    trace_num.push_back(num);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_trace();
        string                cmd;
        int                   a;
        int                   b;
        int                   stamp;
        int                   pending_e;
        bit                   busy;
        bit                   drop_next;
        sddac_pkg::apb_data_t rd;
        pending_e = 0;
        busy      = 1'b0;
        drop_next = 1'b0;
        foreach (trace_text[k]) begin
            void'($sscanf(trace_text[k], "%s", cmd));
            if (cmd == "W" || cmd == "R") begin
                void'($sscanf(trace_text[k], "%s %h %h", cmd, a, b));
                if (busy) begin
                    wait_done();
                    busy = 1'b0;
                end
                if (cmd == "W") begin
                    apb_write(a[`SDDAC_APB_AW-1:0], sddac_pkg::apb_data_t'(b));
                end else begin
                    apb_read(a[`SDDAC_APB_AW-1:0], rd);
                    check_reg($sformatf("trace line %0d read", trace_num[k]),
                              sddac_pkg::apb_data_t'(b), rd);
                end
                idle_gap();
            end else if (cmd == "E") begin
                void'($sscanf(trace_text[k], "%s %d %d", cmd, a, b));
                exp_l_q.push_back(sddac_pkg::sample_t'(a));
                exp_r_q.push_back(sddac_pkg::sample_t'(b));
                exp_line_q.push_back(trace_num[k]);
                pending_e++;
            end else if (cmd == "X") begin
                drop_next = 1'b1;
            end else if (cmd == "S") begin
                void'($sscanf(trace_text[k], "%s %d %d", cmd, a, b));
                if (drop_next) begin
                    // Sent while the filter is still busy
                    send_sample(a, b, stamp);
                    drop_next = 1'b0;
                end else begin
                    if (busy) begin
                        wait_done();
                        busy = 1'b0;
                    end
                    send_sample(a, b, stamp);
                    if (pending_e > 0) begin
                        accept_stamp = stamp;
                        busy         = 1'b1;
                        pending_e    = 0;
                    end else begin
                        repeat (100) @(posedge clk);
                    end
                end
            end else begin
                other_errors++;
                $display("unknown command on trace line %0d", trace_num[k]);
            end
        end
        if (busy) begin
            wait_done();
        end
        repeat (20) @(posedge clk);
        if (exp_l_q.size() != 0) begin
            other_errors++;
            $display("%0d expected outputs never appeared", exp_l_q.size());
        end
    endtask

    task automatic report_and_finish();
        $display("errors: value %0d, timing %0d, other %0d",
                 value_errors, timing_errors, other_errors);
        if (value_errors + timing_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        bit ok;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        in_valid = 1'b0;
        in_l     = '0;
        in_r     = '0;
        void'($urandom(32'hdca1));
        load_trace(ok);
        if (!ok) begin
            $display("could not open the trace file");
            $display(">>> FAIL");
            $finish;
        end else begin
            n_cmds = trace_text.size();
            loaded = 1'b1;
            wait (!reset);
            @(posedge clk);
            run_trace();
            report_and_finish();
        end
    end

    // Watchdog sized from the trace length
    initial begin
        wait (loaded);
        repeat (n_cmds * 120) @(posedge clk);
        $display("run timed out after %0d cycles with %0d expected outputs still queued",
                 n_cmds * 120, exp_l_q.size());
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
// Clock and reset source for the testbench
// 8 ns clock, reset held high for the first 8 cycles

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule
